// ==== verilog/serdes_pkg.sv ====
package serdes_pkg;

  // ==============================
  // sizing
  // ==============================

  // bits in one sample word.
  localparam int sample_w = 32;

  // samples carried by one frame.
  localparam int n_samples = 8;

  // sample index width, log2 of n_samples.
  localparam int sel_w = 3;

  // counter width that can hold n_samples itself.
  localparam int cnt_w = 4;

  // ==============================
  // state encodings
  // ==============================

  // serializer controller.
  localparam logic ser_idle = 1'b0;
  localparam logic ser_send = 1'b1;

  // deserializer.
  localparam logic des_collect = 1'b0;
  localparam logic des_full    = 1'b1;

  // ==============================
  // types
  // ==============================

  typedef logic [sample_w-1:0] sample_t;

  // index 0 goes out on the lane first.
  typedef struct packed {
    sample_t [n_samples-1:0] samples;
  } frame_t;

endpackage

// ==== verilog/serdes_serializer_control.sv ====
`timescale 1ns/1ps

module serdes_serializer_control (
  input  logic                         clk,
  input  logic                         reset,

  input  logic                         recv_val,
  output logic                         recv_rdy,

  output logic                         send_val,
  input  logic                         send_rdy,

  output logic                         reg_en,
  output logic [serdes_pkg::sel_w-1:0] mux_sel
);

  logic                       state;
  logic                       state_next;
  // one bit wider than mux_sel so it can reach n_samples.
  logic [serdes_pkg::sel_w:0] beat_cnt;
  logic [serdes_pkg::sel_w:0] beat_cnt_next;

  assign mux_sel = beat_cnt[serdes_pkg::sel_w-1:0];

  // ==============================
  // outputs and next state
  // ==============================

  always_comb begin
    reg_en        = 1'b0;
    recv_rdy      = 1'b0;
    send_val      = 1'b0;
    state_next    = state;
    beat_cnt_next = beat_cnt;
    case (state)
      serdes_pkg::ser_idle: begin
        reg_en   = 1'b1;
        recv_rdy = 1'b1;
        if (recv_val) begin
          state_next = serdes_pkg::ser_send;
        end
      end
      serdes_pkg::ser_send: begin
        send_val = 1'b1;
        if (send_rdy) begin
          beat_cnt_next = beat_cnt + 1'b1;
          // last beat accepted, back to idle with index 0.
          if (beat_cnt_next == (serdes_pkg::sel_w + 1)'(serdes_pkg::n_samples)) begin
            beat_cnt_next = '0;
            state_next    = serdes_pkg::ser_idle;
          end
        end
      end
      default: begin
        state_next    = serdes_pkg::ser_idle;
        beat_cnt_next = '0;
      end
    endcase
  end

  // ==============================
  // state registers
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= serdes_pkg::ser_idle;
      beat_cnt <= '0;
    end else begin
      state    <= state_next;
      beat_cnt <= beat_cnt_next;
    end
  end

endmodule

// ==== verilog/serdes_serializer.sv ====
`timescale 1ns/1ps

module serdes_serializer (
  input  logic                clk,
  input  logic                reset,

  // frame input channel.
  input  serdes_pkg::frame_t  recv_msg,
  input  logic                recv_val,
  output logic                recv_rdy,

  // serial output channel.
  output serdes_pkg::sample_t send_msg,
  output logic                send_val,
  input  logic                send_rdy
);

  logic                         reg_en;
  logic [serdes_pkg::sel_w-1:0] mux_sel;
  serdes_pkg::frame_t           frame_q;

  // ==============================
  // frame capture
  // ==============================

  // loads every idle cycle, so the transfer edge captures the offered frame.
  always_ff @(posedge clk) begin
    if (reset) begin
      frame_q <= '0;
    end else if (reg_en) begin
      frame_q <= recv_msg;
    end
  end

  // ==============================
  // sample select
  // ==============================

  // one sample per beat, index from the controller.
  always_comb begin
    send_msg = frame_q.samples[mux_sel];
  end

  // ==============================
  // controller
  // ==============================

  serdes_serializer_control ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .reg_en   (reg_en),
    .mux_sel  (mux_sel)
  );

endmodule

// ==== verilog/serdes_deserializer.sv ====
`timescale 1ns/1ps

module serdes_deserializer (
  input  logic                clk,
  input  logic                reset,

  // serial input channel.
  input  serdes_pkg::sample_t recv_msg,
  input  logic                recv_val,
  output logic                recv_rdy,

  // frame output channel.
  output serdes_pkg::frame_t  send_msg,
  output logic                send_val,
  input  logic                send_rdy
);

  logic                         state;
  logic [serdes_pkg::cnt_w-1:0] count;
  serdes_pkg::frame_t           frame_q;
  logic                         recv_fire;
  logic                         send_fire;
  logic                         last_beat;

  // ==============================
  // handshake
  // ==============================

  assign recv_rdy  = (state == serdes_pkg::des_collect);
  assign send_val  = (state == serdes_pkg::des_full);
  assign recv_fire = recv_val && recv_rdy;
  assign send_fire = send_val && send_rdy;

  // slot n_samples-1 is the final word of a frame.
  assign last_beat = (count == serdes_pkg::cnt_w'(serdes_pkg::n_samples - 1));

  // ==============================
  // control
  // ==============================

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= serdes_pkg::des_collect;
      count <= '0;
    end else begin
      case (state)
        serdes_pkg::des_collect: begin
          if (recv_fire) begin
            count <= count + 1'b1;
            if (last_beat) begin
              state <= serdes_pkg::des_full;
            end
          end
        end
        serdes_pkg::des_full: begin
          // frame taken, start over at slot 0.
          if (send_fire) begin
            count <= '0;
            state <= serdes_pkg::des_collect;
          end
        end
        default: begin
          state <= serdes_pkg::des_collect;
          count <= '0;
        end
      endcase
    end
  end

  // ==============================
  // frame assembly
  // ==============================

  // words land in arrival order, the frame holds while full.
  always_ff @(posedge clk) begin
    if (recv_fire) begin
      frame_q.samples[count[serdes_pkg::sel_w-1:0]] <= recv_msg;
    end
  end

  assign send_msg = frame_q;

endmodule

// ==== verilog/serdes_top.sv ====
`timescale 1ns/1ps

module serdes_top (
  input  logic                clk,
  input  logic                reset,

  // transmit frame input.
  input  serdes_pkg::frame_t  tx_frame_msg,
  input  logic                tx_frame_val,
  output logic                tx_frame_rdy,

  // transmit serial lane.
  output serdes_pkg::sample_t tx_msg,
  output logic                tx_val,
  input  logic                tx_rdy,

  // receive serial lane.
  input  serdes_pkg::sample_t rx_msg,
  input  logic                rx_val,
  output logic                rx_rdy,

  // receive frame output.
  output serdes_pkg::frame_t  rx_frame_msg,
  output logic                rx_frame_val,
  input  logic                rx_frame_rdy
);

  // ==============================
  // transmit half
  // ==============================

  serdes_serializer tx (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (tx_frame_msg),
    .recv_val (tx_frame_val),
    .recv_rdy (tx_frame_rdy),
    .send_msg (tx_msg),
    .send_val (tx_val),
    .send_rdy (tx_rdy)
  );

  // ==============================
  // receive half
  // ==============================

  // lanes stay separate so the serial path can go through a channel or a loopback.
  serdes_deserializer rx (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (rx_msg),
    .recv_val (rx_val),
    .recv_rdy (rx_rdy),
    .send_msg (rx_frame_msg),
    .send_val (rx_frame_val),
    .send_rdy (rx_frame_rdy)
  );

endmodule

// ==== dv/serdes_assertions.sv ====
`timescale 1ns/1ps

module serdes_assertions (
  input logic                clk,
  input logic                reset,
  input logic                tx_frame_rdy,
  input serdes_pkg::sample_t tx_msg,
  input logic                tx_val,
  input logic                tx_rdy,
  input logic                rx_rdy,
  input serdes_pkg::frame_t  rx_frame_msg,
  input logic                rx_frame_val,
  input logic                rx_frame_rdy
);

  // number of failed properties so far.
  int fail_count = 0;

  // ==============================
  // reset state
  // ==============================

  reset_state: assert property (
    @(posedge clk) $fell(reset) |-> (!tx_val && !rx_frame_val && tx_frame_rdy && rx_rdy)
  ) else begin
    $error("handshake outputs are not idle in the first cycle after reset");
    fail_count++;
  end

  // ==============================
  // back-pressure hold
  // ==============================

  tx_hold: assert property (
    @(posedge clk) disable iff (reset)
      (tx_val && !tx_rdy) |=> (tx_val && $stable(tx_msg))
  ) else begin
    $error("serial lane changed while it was stalled");
    fail_count++;
  end

  rx_frame_hold: assert property (
    @(posedge clk) disable iff (reset)
      (rx_frame_val && !rx_frame_rdy) |=> (rx_frame_val && $stable(rx_frame_msg))
  ) else begin
    $error("output frame changed while it was stalled");
    fail_count++;
  end

  // ==============================
  // no capture while busy
  // ==============================

  tx_busy: assert property (
    @(posedge clk) disable iff (reset) tx_val |-> !tx_frame_rdy
  ) else begin
    $error("serializer accepts a frame while it is sending");
    fail_count++;
  end

  // a full frame blocks the lane.
  rx_busy: assert property (
    @(posedge clk) disable iff (reset) rx_frame_val |-> !rx_rdy
  ) else begin
    $error("deserializer accepts a beat while its frame is full");
    fail_count++;
  end

endmodule

bind serdes_top serdes_assertions chk (
  .clk          (clk),
  .reset        (reset),
  .tx_frame_rdy (tx_frame_rdy),
  .tx_msg       (tx_msg),
  .tx_val       (tx_val),
  .tx_rdy       (tx_rdy),
  .rx_rdy       (rx_rdy),
  .rx_frame_msg (rx_frame_msg),
  .rx_frame_val (rx_frame_val),
  .rx_frame_rdy (rx_frame_rdy)
);

// ==== dv/serdes_tb.sv ====
`timescale 1ns/1ps

module serdes_tb;

  localparam int n_frames   = 40;
  // about 9 cycles a frame, up to 4x with stalls, plus offer gaps and output waits.
  localparam int max_cycles = n_frames * 100;

  logic                clk          = 1'b0;
  logic                reset        = 1'b1;
  serdes_pkg::frame_t  tx_frame_msg = '0;
  logic                tx_frame_val = 1'b0;
  logic                tx_frame_rdy;
  serdes_pkg::sample_t tx_msg;
  logic                tx_val;
  logic                tx_rdy;
  serdes_pkg::sample_t rx_msg;
  logic                rx_val;
  logic                rx_rdy;
  serdes_pkg::frame_t  rx_frame_msg;
  logic                rx_frame_val;
  logic                rx_frame_rdy = 1'b0;
  logic                stall_ok     = 1'b0;

  int                  seed       = 19;
  int                  gap        = 0;
  int                  offered    = 0;
  int                  frames_in  = 0;
  int                  frames_out = 0;
  int                  beats      = 0;
  int                  cycles     = 0;
  serdes_pkg::frame_t  serial_q[$];
  serdes_pkg::frame_t  loop_q[$];
  serdes_pkg::frame_t  cur_frame;
  serdes_pkg::sample_t exp_sample;

  always #20 clk = ~clk;

  serdes_top uut (
    .clk          (clk),
    .reset        (reset),
    .tx_frame_msg (tx_frame_msg),
    .tx_frame_val (tx_frame_val),
    .tx_frame_rdy (tx_frame_rdy),
    .tx_msg       (tx_msg),
    .tx_val       (tx_val),
    .tx_rdy       (tx_rdy),
    .rx_msg       (rx_msg),
    .rx_val       (rx_val),
    .rx_rdy       (rx_rdy),
    .rx_frame_msg (rx_frame_msg),
    .rx_frame_val (rx_frame_val),
    .rx_frame_rdy (rx_frame_rdy)
  );

  // ==============================
  // loopback with stalls
  // ==============================

  // a stalled beat is hidden from the receiver as well.
  assign rx_msg = tx_msg;
  assign rx_val = tx_val && stall_ok;
  assign tx_rdy = rx_rdy && stall_ok;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input logic [255:0] expected,
                                 input logic [255:0] actual);
    stop_with_failure($sformatf("ERROR %s expected=%0h actual=%0h", test, expected, actual));
  endtask

  // ==============================
  // stimulus
  // ==============================

  always @(posedge clk) begin
    if (reset) begin
      stall_ok     <= 1'b0;
      rx_frame_rdy <= 1'b0;
      tx_frame_val <= 1'b0;
    end else begin
      // lane ready three beats in four, frame output ready half the time.
      stall_ok     <= (($random(seed) & 3) != 0);
      rx_frame_rdy <= (($random(seed) & 1) != 0);
      if (tx_frame_val && tx_frame_rdy) begin
        tx_frame_val <= 1'b0;
        gap          <= $random(seed) & 7;
      end else if (!tx_frame_val && offered < n_frames) begin
        if (gap == 0) begin
          for (int j = 0; j < serdes_pkg::n_samples; j++) begin
            tx_frame_msg.samples[j] <= $random(seed);
          end
          tx_frame_val <= 1'b1;
          offered      <= offered + 1;
        end else begin
          gap <= gap - 1;
        end
      end
    end
  end

  // ==============================
  // scoreboard
  // ==============================

  always @(posedge clk) begin
    if (!reset) begin
      if (tx_frame_val && tx_frame_rdy) begin
        if (frames_in > 0 && beats != serdes_pkg::n_samples) begin
          report_mismatch("beat_count", serdes_pkg::n_samples, beats);
        end
        beats = 0;
        frames_in++;
        serial_q.push_back(tx_frame_msg);
        loop_q.push_back(tx_frame_msg);
      end
      if (tx_val && tx_rdy) begin
        if (serial_q.size() == 0 || beats >= serdes_pkg::n_samples) begin
          report_mismatch("beat_count", serdes_pkg::n_samples, beats + 1);
        end
        cur_frame  = serial_q[0];
        exp_sample = cur_frame.samples[beats];
        if (tx_msg !== exp_sample) begin
          report_mismatch("serial_order", exp_sample, tx_msg);
        end
        beats++;
        if (beats == serdes_pkg::n_samples) begin
          void'(serial_q.pop_front());
        end
      end
      if (rx_frame_val && rx_frame_rdy) begin
        if (loop_q.size() == 0) begin
          stop_with_failure("a frame came out of the receiver that was never sent in");
        end
        if (rx_frame_msg !== loop_q[0]) begin
          report_mismatch("loopback", loop_q[0], rx_frame_msg);
        end
        void'(loop_q.pop_front());
        frames_out++;
      end
    end
  end

  // ==============================
  // timeout and assertion watch
  // ==============================

  always @(posedge clk) begin
    cycles++;
    if (uut.chk.fail_count != 0) begin
      stop_with_failure("a protocol assertion on the DUT ports failed");
    end else if (cycles >= max_cycles) begin
      stop_with_failure("timeout: frames did not complete");
    end
  end

  initial begin
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    wait (frames_out == n_frames);
    @(posedge clk);
    if (uut.chk.fail_count != 0) begin
      stop_with_failure("a protocol assertion on the DUT ports failed");
    end else begin
      $display("Test OK");
      $finish;
    end
  end

endmodule

// ==== build.f ====
verilog/serdes_pkg.sv
verilog/serdes_serializer_control.sv
verilog/serdes_serializer.sv
verilog/serdes_deserializer.sv
verilog/serdes_top.sv
dv/serdes_assertions.sv
dv/serdes_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module serdes_tb \
  -f build.f -o serdes_sim > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/serdes_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "Test FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
